// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_occl
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= *** PASSED ***

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) design/*.sv sim/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== design/anchor_transform.sv ====
// anchor data is valid the cycle after the read strobe; the view matrix must hold for the whole job
`timescale 1ns/1ns

module anchor_transform (
    input  logic                  clk,
    input  logic                  rstn,
    input  occl_pkg::job_cfg_t    cfg_i,
    input  logic                  anchor_rd_i,
    input  occl_pkg::fp16_t [2:0] anchor_data_i,   // {x, y, z}
    output occl_pkg::cam_pos_t    cam_o
);

    occl_pkg::fix_t [2:0][3:0] mat_q;
    occl_pkg::fix_t [2:0]      vec_q;    // x, y, z
    occl_pkg::fix_t [2:0][3:0] prod_q;
    occl_pkg::fix_t [2:0][1:0] pair_q;
    logic                      data_vld;
    logic [2:0]                vld_q;

    // matrix settles during prepare
    always_ff @(posedge clk) begin
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 4; c++) begin
                mat_q[r][c] <= occl_pkg::fp16_to_fix(cfg_i.view[r][c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            data_vld <= 1'b0;
            vld_q    <= '0;
        end else begin
            data_vld <= anchor_rd_i;
            vld_q    <= {vld_q[1:0], data_vld};
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < 3; j++) begin
            vec_q[j] <= occl_pkg::fp16_to_fix(anchor_data_i[2-j]);
        end
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                prod_q[r][c] <= occl_pkg::fix_mul(mat_q[r][c], vec_q[c]);
            end
            prod_q[r][3] <= occl_pkg::fix_mul(mat_q[r][3], occl_pkg::ONE_FIX);   // homogeneous w
            pair_q[r][0] <= occl_pkg::fix_add(prod_q[r][0], prod_q[r][1]);
            pair_q[r][1] <= occl_pkg::fix_add(prod_q[r][2], prod_q[r][3]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cam_o.valid <= 1'b0;
        end else begin
            cam_o.valid <= vld_q[2];
        end
        cam_o.x <= occl_pkg::fix_add(pair_q[0][0], pair_q[0][1]);
        cam_o.y <= occl_pkg::fix_add(pair_q[1][0], pair_q[1][1]);
        cam_o.z <= occl_pkg::fix_add(pair_q[2][0], pair_q[2][1]);
    end

endmodule

// ==== design/block_update.sv ====
// block SRAM returns read data one cycle after the read; kept points are never closer than 2 cycles
`timescale 1ns/1ns

module block_update (
    input  logic                  clk,
    input  logic                  rstn,
    input  occl_pkg::grid_pos_t   grid_i,
    input  occl_pkg::block_word_t block_rdata_i,
    output logic                  block_cen_n_o,
    output logic                  block_we_o,
    output occl_pkg::block_addr_t block_addr_o,
    output occl_pkg::block_word_t block_wdata_o
);

    logic                               rd_hit;
    logic [1:0]                         word_col;
    occl_pkg::lane_t                    rd_lane;
    occl_pkg::block_addr_t              rd_addr;
    logic                               wr_pend;
    occl_pkg::block_addr_t              wr_addr;
    occl_pkg::lane_t                    wr_lane;
    occl_pkg::depth_t                   wr_depth;
    logic [occl_pkg::LANE_W-1:0]        old_lane;
    occl_pkg::depth_t                   keep_depth;

    assign rd_hit = grid_i.valid && grid_i.in_cell;

    // word = gy*3 + gx/7, lane = gx mod 7
    always_comb begin
        if (grid_i.gx < occl_pkg::blk_pos_t'(occl_pkg::LANES)) begin
            word_col = 2'd0;
            rd_lane  = occl_pkg::lane_t'(grid_i.gx);
        end else if (grid_i.gx < occl_pkg::blk_pos_t'(2 * occl_pkg::LANES)) begin
            word_col = 2'd1;
            rd_lane  = occl_pkg::lane_t'(grid_i.gx - occl_pkg::blk_pos_t'(occl_pkg::LANES));
        end else begin
            word_col = 2'd2;
            rd_lane  = occl_pkg::lane_t'(grid_i.gx - occl_pkg::blk_pos_t'(2 * occl_pkg::LANES));
        end
        rd_addr = occl_pkg::block_addr_t'(grid_i.gy) * occl_pkg::block_addr_t'(occl_pkg::WORDS_PER_ROW)
                  + occl_pkg::block_addr_t'(word_col);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= rd_hit;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr  <= rd_addr;
        wr_lane  <= rd_lane;
        wr_depth <= grid_i.depth;
    end

    always_comb begin
        old_lane   = block_rdata_i[int'(wr_lane) * occl_pkg::LANE_W +: occl_pkg::LANE_W];
        // empty lane takes the new depth, otherwise the nearer one
        keep_depth = (!old_lane[occl_pkg::LANE_W-1] || wr_depth < occl_pkg::depth_t'(old_lane))
                     ? wr_depth : occl_pkg::depth_t'(old_lane);
        block_wdata_o = block_rdata_i;
        block_wdata_o[occl_pkg::BLOCK_DATA_W-1] = 1'b0;   // spare bit
        block_wdata_o[int'(wr_lane) * occl_pkg::LANE_W +: occl_pkg::LANE_W] = {1'b1, keep_depth};
    end

    assign block_cen_n_o = !(rd_hit || wr_pend);
    assign block_we_o    = wr_pend;
    assign block_addr_o  = wr_pend ? wr_addr : rd_addr;   // write phase owns the port

endmodule

// ==== design/frustum_project.sv ====
// tangents and depth span must be positive; points off the 80x80x80 grid or the cell are not kept
`timescale 1ns/1ns

module frustum_project (
    input  logic                clk,
    input  logic                rstn,
    input  occl_pkg::job_cfg_t  cfg_i,
    input  occl_pkg::cam_pos_t  cam_i,
    output occl_pkg::grid_pos_t grid_o
);

    occl_pkg::fix_t     scale_x, scale_y, depth_step;
    logic               vld1, vld2;
    occl_pkg::fix_t     xd, yd, zd;
    occl_pkg::fix_t     xs, ys, zs;
    occl_pkg::fix_int_t x_int, y_int, z_int;
    occl_pkg::fix_int_t x_lo, y_lo;
    logic               x_in, y_in, z_in;

    // constant over a job, ready after prepare
    always_ff @(posedge clk) begin
        scale_x    <= occl_pkg::fix_div(occl_pkg::HALF_GRID_FIX, cfg_i.tan_x);
        scale_y    <= occl_pkg::fix_div(occl_pkg::HALF_GRID_FIX, cfg_i.tan_y);
        depth_step <= occl_pkg::fix_div(cfg_i.z_span, occl_pkg::GRID_FIX);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            vld1 <= 1'b0;
            vld2 <= 1'b0;
        end else begin
            vld1 <= cam_i.valid;
            vld2 <= vld1;
        end
    end

    always_ff @(posedge clk) begin
        xd <= occl_pkg::fix_div(cam_i.x, cam_i.z);   // perspective divide
        yd <= occl_pkg::fix_div(cam_i.y, cam_i.z);
        zd <= occl_pkg::fix_div(cam_i.z, depth_step);
        xs <= occl_pkg::fix_add(occl_pkg::fix_mul(xd, scale_x), occl_pkg::HALF_GRID_FIX);
        ys <= occl_pkg::fix_add(occl_pkg::fix_mul(yd, scale_y), occl_pkg::HALF_GRID_FIX);
        zs <= zd;
    end

    // floor, negative zero counts as zero
    always_comb begin
        x_lo  = occl_pkg::fix_int_t'(cfg_i.cell_x) * occl_pkg::fix_int_t'(occl_pkg::CELL_SPAN);
        y_lo  = occl_pkg::fix_int_t'(cfg_i.cell_y) * occl_pkg::fix_int_t'(occl_pkg::CELL_SPAN);
        x_int = xs[occl_pkg::FIX_W-2:occl_pkg::FRAC_BITS];
        y_int = ys[occl_pkg::FIX_W-2:occl_pkg::FRAC_BITS];
        z_int = zs[occl_pkg::FIX_W-2:occl_pkg::FRAC_BITS];
        x_in  = !(xs[occl_pkg::FIX_W-1] && xs[occl_pkg::FIX_W-2:0] != '0) && x_int >= x_lo
                && x_int < x_lo + occl_pkg::fix_int_t'(occl_pkg::CELL_SPAN);
        y_in  = !(ys[occl_pkg::FIX_W-1] && ys[occl_pkg::FIX_W-2:0] != '0) && y_int >= y_lo
                && y_int < y_lo + occl_pkg::fix_int_t'(occl_pkg::CELL_SPAN);
        z_in  = !(zs[occl_pkg::FIX_W-1] && zs[occl_pkg::FIX_W-2:0] != '0)
                && z_int < occl_pkg::fix_int_t'(occl_pkg::GRID_SPAN);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            grid_o.valid <= 1'b0;
        end else begin
            grid_o.valid <= vld2;
        end
        grid_o.in_cell <= x_in && y_in && z_in;
        grid_o.gx      <= occl_pkg::blk_pos_t'(x_int - x_lo);   // offset inside the cell
        grid_o.gy      <= occl_pkg::blk_pos_t'(y_int - y_lo);
        grid_o.depth   <= occl_pkg::depth_t'(z_int);
    end

endmodule

// ==== design/occl_ctrl.sv ====
// start_i is taken only in IDLE; anchor_last_i must not be below anchor_first_i
`timescale 1ns/1ns

module occl_ctrl (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start_i,
    input  occl_pkg::anchor_addr_t anchor_first_i,
    input  occl_pkg::anchor_addr_t anchor_last_i,
    input  occl_pkg::cell_idx_t    cell_x_i,
    input  occl_pkg::cell_idx_t    cell_y_i,
    input  occl_pkg::fix_t         tan_x_i,
    input  occl_pkg::fix_t         tan_y_i,
    input  occl_pkg::fix_t         z_span_i,
    input  occl_pkg::view_mat_t    view_i,
    output occl_pkg::job_cfg_t     cfg_o,
    output logic                   anchor_cen_n_o,
    output logic                   anchor_rd_o,
    output occl_pkg::anchor_addr_t anchor_addr_o,
    output logic                   done_o
);

    occl_pkg::ctrl_state_e                     state;
    occl_pkg::anchor_addr_t                    last_addr;
    logic                                      prep_cnt;
    logic                                      phase;     // odd cycles of SCAN are idle
    logic [$clog2(occl_pkg::DRAIN_CYCLES)-1:0] drain_cnt;
    logic                                      take_job;

    assign take_job       = (state == occl_pkg::IDLE) && start_i;
    assign anchor_rd_o    = (state == occl_pkg::SCAN) && !phase;
    assign anchor_cen_n_o = !anchor_rd_o;
    assign done_o = (state == occl_pkg::DRAIN) && (int'(drain_cnt) == occl_pkg::DRAIN_CYCLES - 1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= occl_pkg::IDLE;
            prep_cnt  <= 1'b0;
            phase     <= 1'b0;
            drain_cnt <= '0;
        end else begin
            case (state)
                occl_pkg::IDLE: begin
                    prep_cnt <= 1'b0;
                    if (start_i) state <= occl_pkg::PREPARE;
                end
                occl_pkg::PREPARE: begin   // two cycles for the scale divisions
                    prep_cnt <= 1'b1;
                    phase    <= 1'b0;
                    if (prep_cnt) state <= occl_pkg::SCAN;
                end
                occl_pkg::SCAN: begin
                    phase     <= !phase;
                    drain_cnt <= '0;
                    if (anchor_rd_o && anchor_addr_o == last_addr) state <= occl_pkg::DRAIN;
                end
                occl_pkg::DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (done_o) state <= occl_pkg::IDLE;
                end
                default: state <= occl_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_job) begin
            cfg_o     <= '{cell_x: cell_x_i, cell_y: cell_y_i, tan_x: tan_x_i,
                           tan_y: tan_y_i, z_span: z_span_i, view: view_i};
            last_addr <= anchor_last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            anchor_addr_o <= '0;
        end else if (take_job) begin
            anchor_addr_o <= anchor_first_i;
        end else if (anchor_rd_o && anchor_addr_o != last_addr) begin
            anchor_addr_o <= anchor_addr_o + 1'b1;
        end
    end

endmodule

// ==== design/occl_pkg.sv ====
// fixed point is sign-magnitude with 6 fraction bits; every helper saturates at 15 magnitude bits
package occl_pkg;

    localparam int FRAC_BITS     = 6;
    localparam int FIX_W         = 16;
    localparam int GRID_SPAN     = 80;
    localparam int CELL_SPAN     = 20;
    localparam int LANES         = 7;
    localparam int LANE_W        = 9;
    localparam int WORDS_PER_ROW = 3;
    localparam int ANCHOR_ADDR_W = 10;
    localparam int BLOCK_ADDR_W  = 6;
    localparam int BLOCK_DATA_W  = 64;
    localparam int XFORM_LAT     = 4;
    localparam int PROJ_LAT      = 3;
    localparam int DRAIN_CYCLES  = 1 + XFORM_LAT + PROJ_LAT + 2;

    typedef logic [15:0]                    fp16_t;
    typedef logic [FIX_W-1:0]               fix_t;
    typedef logic [FIX_W-FRAC_BITS-2:0]     fix_int_t;   // integer part of a magnitude
    typedef logic [1:0]                     cell_idx_t;
    typedef logic [ANCHOR_ADDR_W-1:0]       anchor_addr_t;
    typedef logic [BLOCK_ADDR_W-1:0]        block_addr_t;
    typedef logic [BLOCK_DATA_W-1:0]        block_word_t;
    typedef logic [7:0]                     depth_t;
    typedef logic [4:0]                     blk_pos_t;   // 0..19 inside a cell
    typedef logic [$clog2(LANES)-1:0]       lane_t;
    typedef fp16_t [2:0][3:0]               view_mat_t;

    localparam logic [FIX_W-2:0] MAG_MAX       = '1;
    localparam fix_t             ONE_FIX       = fix_t'(1 << FRAC_BITS);
    localparam fix_t             HALF_GRID_FIX = fix_t'((GRID_SPAN / 2) << FRAC_BITS);
    localparam fix_t             GRID_FIX      = fix_t'(GRID_SPAN << FRAC_BITS);

    typedef struct packed {
        cell_idx_t cell_x;
        cell_idx_t cell_y;
        fix_t      tan_x;
        fix_t      tan_y;
        fix_t      z_span;
        view_mat_t view;
    } job_cfg_t;

    typedef struct packed {
        logic valid;
        fix_t x;
        fix_t y;
        fix_t z;
    } cam_pos_t;

    typedef struct packed {
        logic     valid;
        logic     in_cell;
        blk_pos_t gx;
        blk_pos_t gy;
        depth_t   depth;
    } grid_pos_t;

    typedef enum logic [1:0] {IDLE, PREPARE, SCAN, DRAIN} ctrl_state_e;

    // value = mant * 2^(exp-25), times 2^6 for the fraction bits
    function automatic fix_t fp16_to_fix(fp16_t a);
        logic [10:0] mant;
        logic [25:0] wide;
        mant = (a[14:10] == 5'd0) ? {1'b0, a[9:0]} : {1'b1, a[9:0]};
        if (a[14:10] >= 5'd19) begin
            wide = {15'd0, mant} << (a[14:10] - 5'd19);
        end else begin
            wide = {15'd0, mant} >> (5'd19 - a[14:10]);   // truncates toward zero
        end
        return {a[15], (wide[25:15] != '0) ? MAG_MAX : wide[14:0]};
    endfunction

    function automatic fix_t fix_mul(fix_t a, fix_t b);
        logic [2*FIX_W-3:0] prod;
        prod = a[FIX_W-2:0] * b[FIX_W-2:0];
        prod = prod >> FRAC_BITS;
        return {a[FIX_W-1] ^ b[FIX_W-1], (prod[2*FIX_W-3:FIX_W-1] != '0) ? MAG_MAX : prod[FIX_W-2:0]};
    endfunction

    function automatic fix_t fix_add(fix_t a, fix_t b);
        logic [FIX_W-1:0] sum;
        sum = {1'b0, a[FIX_W-2:0]} + {1'b0, b[FIX_W-2:0]};
        if (a[FIX_W-1] == b[FIX_W-1]) begin
            return {a[FIX_W-1], sum[FIX_W-1] ? MAG_MAX : sum[FIX_W-2:0]};
        end else if (a[FIX_W-2:0] > b[FIX_W-2:0]) begin
            return {a[FIX_W-1], a[FIX_W-2:0] - b[FIX_W-2:0]};
        end else if (b[FIX_W-2:0] > a[FIX_W-2:0]) begin
            return {b[FIX_W-1], b[FIX_W-2:0] - a[FIX_W-2:0]};
        end
        return '0;
    endfunction

    // divide by zero gives full scale
    function automatic fix_t fix_div(fix_t num, fix_t den);
        logic [FIX_W+FRAC_BITS-2:0] quo;
        quo = '0;
        if (den[FIX_W-2:0] != '0) begin
            quo = {num[FIX_W-2:0], FRAC_BITS'(0)} / {FRAC_BITS'(0), den[FIX_W-2:0]};
        end
        if (den[FIX_W-2:0] == '0 || quo[FIX_W+FRAC_BITS-2:FIX_W-1] != '0) begin
            return {num[FIX_W-1] ^ den[FIX_W-1], MAG_MAX};
        end
        return {num[FIX_W-1] ^ den[FIX_W-1], quo[FIX_W-2:0]};
    endfunction

endpackage

// ==== design/occl_top.sv ====
// both SRAMs have one cycle read latency and must accept an access on every cycle it is issued
`timescale 1ns/1ns

module occl_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  start_i,
    input  occl_pkg::anchor_addr_t anchor_first_i,
    input  occl_pkg::anchor_addr_t anchor_last_i,
    input  occl_pkg::cell_idx_t   cell_x_i,
    input  occl_pkg::cell_idx_t   cell_y_i,
    input  occl_pkg::fix_t        tan_x_i,
    input  occl_pkg::fix_t        tan_y_i,
    input  occl_pkg::fix_t        z_span_i,
    input  occl_pkg::view_mat_t   view_i,
    output logic                  anchor_cen_n_o,
    output occl_pkg::anchor_addr_t anchor_addr_o,
    input  occl_pkg::fp16_t [2:0] anchor_data_i,
    output logic                  block_cen_n_o,
    output logic                  block_we_o,
    output occl_pkg::block_addr_t block_addr_o,
    output occl_pkg::block_word_t block_wdata_o,
    input  occl_pkg::block_word_t block_rdata_i,
    output logic                  done_o
);

    occl_pkg::job_cfg_t  cfg;
    logic                anchor_rd;
    occl_pkg::cam_pos_t  cam;
    occl_pkg::grid_pos_t grid;

    occl_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .start_i(start_i),
        .anchor_first_i(anchor_first_i), .anchor_last_i(anchor_last_i),
        .cell_x_i(cell_x_i), .cell_y_i(cell_y_i),
        .tan_x_i(tan_x_i), .tan_y_i(tan_y_i), .z_span_i(z_span_i), .view_i(view_i),
        .cfg_o(cfg), .anchor_cen_n_o(anchor_cen_n_o), .anchor_rd_o(anchor_rd),
        .anchor_addr_o(anchor_addr_o), .done_o(done_o)
    );

    anchor_transform u_xform (
        .clk(clk), .rstn(rstn), .cfg_i(cfg),
        .anchor_rd_i(anchor_rd), .anchor_data_i(anchor_data_i), .cam_o(cam)
    );

    frustum_project u_proj (
        .clk(clk), .rstn(rstn), .cfg_i(cfg), .cam_i(cam), .grid_o(grid)
    );

    block_update u_block (
        .clk(clk), .rstn(rstn), .grid_i(grid), .block_rdata_i(block_rdata_i),
        .block_cen_n_o(block_cen_n_o), .block_we_o(block_we_o),
        .block_addr_o(block_addr_o), .block_wdata_o(block_wdata_o)
    );

endmodule

// ==== sim/occl_checker.sv ====
// watches occl_top ports only; block memory model starts all zero like the testbench SRAM
`timescale 1ns/1ns

module occl_checker (
    input logic                  clk,
    input logic                  rstn,
    input logic                  start_i,
    input occl_pkg::anchor_addr_t anchor_first_i,
    input occl_pkg::anchor_addr_t anchor_last_i,
    input occl_pkg::cell_idx_t   cell_x_i,
    input occl_pkg::cell_idx_t   cell_y_i,
    input occl_pkg::fix_t        tan_x_i,
    input occl_pkg::fix_t        tan_y_i,
    input occl_pkg::fix_t        z_span_i,
    input occl_pkg::view_mat_t   view_i,
    input logic                  anchor_cen_n_o,
    input occl_pkg::anchor_addr_t anchor_addr_o,
    input occl_pkg::fp16_t [2:0] anchor_data_i,
    input logic                  block_cen_n_o,
    input logic                  block_we_o,
    input occl_pkg::block_addr_t block_addr_o,
    input occl_pkg::block_word_t block_wdata_o,
    input logic                  done_o
);

    int                    errors = 0;
    int                    kept_total = 0;
    occl_pkg::block_word_t model_mem [0:63];
    occl_pkg::job_cfg_t    cfg;
    occl_pkg::anchor_addr_t exp_addr, last_addr;
    logic [16:0]           kept_q[$];   // {word, lane, depth}
    logic [16:0]           wr_exp;
    logic                  busy, all_read, strobe_prev, data_due, wr_due;
    int                    cyc, done_cyc, kept, writes;

    initial begin
        for (int i = 0; i < 64; i++) model_mem[i] = '0;
    end

    task automatic report_fail(string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // integer grid coordinate or -1 when the floor is negative
    function automatic int grid_int(occl_pkg::fix_t v);
        if (v[15] && v[14:0] != '0) return -1;
        return int'(v[14:6]);
    endfunction

    task automatic model_anchor(occl_pkg::fp16_t [2:0] d);
        occl_pkg::fix_t v[4];
        occl_pkg::fix_t c[3];
        occl_pkg::fix_t xs, ys, zs;
        int gx, gy, gz, lx, ly;
        v[0] = occl_pkg::fp16_to_fix(d[2]);
        v[1] = occl_pkg::fp16_to_fix(d[1]);
        v[2] = occl_pkg::fp16_to_fix(d[0]);
        v[3] = 16'd64;   // w = 1.0
        for (int r = 0; r < 3; r++) begin
            c[r] = occl_pkg::fix_add(
                occl_pkg::fix_add(occl_pkg::fix_mul(occl_pkg::fp16_to_fix(cfg.view[r][0]), v[0]),
                                  occl_pkg::fix_mul(occl_pkg::fp16_to_fix(cfg.view[r][1]), v[1])),
                occl_pkg::fix_add(occl_pkg::fix_mul(occl_pkg::fp16_to_fix(cfg.view[r][2]), v[2]),
                                  occl_pkg::fix_mul(occl_pkg::fp16_to_fix(cfg.view[r][3]), v[3])));
        end
        xs = occl_pkg::fix_add(occl_pkg::fix_mul(occl_pkg::fix_div(c[0], c[2]),
                 occl_pkg::fix_div(16'd40 << 6, cfg.tan_x)), 16'd40 << 6);
        ys = occl_pkg::fix_add(occl_pkg::fix_mul(occl_pkg::fix_div(c[1], c[2]),
                 occl_pkg::fix_div(16'd40 << 6, cfg.tan_y)), 16'd40 << 6);
        zs = occl_pkg::fix_div(c[2], occl_pkg::fix_div(cfg.z_span, 16'd80 << 6));
        gx = grid_int(xs);
        gy = grid_int(ys);
        gz = grid_int(zs);
        lx = gx - 20 * int'(cfg.cell_x);
        ly = gy - 20 * int'(cfg.cell_y);
        if (gx >= 0 && gy >= 0 && gz >= 0 && gz < 80 && lx >= 0 && lx < 20
            && ly >= 0 && ly < 20) begin
            kept_q.push_back({6'(ly * 3 + lx / 7), 3'(lx % 7), 8'(gz)});
            kept++;
            kept_total++;
        end
    endtask

    task automatic check_block();
        occl_pkg::block_word_t exp_word;
        logic [8:0]            old;
        logic [7:0]            nd;
        int                    lane;
        if (block_cen_n_o) return;
        if (!block_we_o) begin
            if (kept_q.size() == 0) begin
                report_fail($sformatf("block read of word %0d with no kept anchor",
                                      block_addr_o));
            end else begin
                wr_exp = kept_q.pop_front();
                wr_due = 1'b1;
                if (block_addr_o != wr_exp[16:11])
                    report_fail($sformatf("block read word %0d, expected %0d",
                                          block_addr_o, wr_exp[16:11]));
            end
        end else if (!wr_due) begin
            report_fail("block write without a preceding read");
        end else begin
            wr_due   = 1'b0;
            lane     = int'(wr_exp[10:8]);
            exp_word = model_mem[wr_exp[16:11]];
            old      = exp_word[lane*9 +: 9];
            nd       = (!old[8] || wr_exp[7:0] < old[7:0]) ? wr_exp[7:0] : old[7:0];
            exp_word[63] = 1'b0;
            exp_word[lane*9 +: 9] = {1'b1, nd};
            if (block_addr_o != wr_exp[16:11] || block_wdata_o != exp_word)
                report_fail($sformatf("block write %0d:%h, expected %0d:%h", block_addr_o,
                                      block_wdata_o, wr_exp[16:11], exp_word));
            model_mem[wr_exp[16:11]] = exp_word;
            writes++;
        end
    endtask

    always @(posedge clk) begin
        cyc++;
        if (!rstn) begin
            busy        = 1'b0;
            strobe_prev = 1'b0;
            data_due    = 1'b0;
            wr_due      = 1'b0;
            done_cyc    = -1;
        end else begin
            if (data_due) model_anchor(anchor_data_i);
            data_due = 1'b0;
            if (start_i && !busy) begin
                cfg       = '{cell_x: cell_x_i, cell_y: cell_y_i, tan_x: tan_x_i,
                              tan_y: tan_y_i, z_span: z_span_i, view: view_i};
                exp_addr  = anchor_first_i;
                last_addr = anchor_last_i;
                busy      = 1'b1;
                all_read  = 1'b0;
                kept      = 0;
                writes    = 0;
            end
            if (!anchor_cen_n_o) begin
                if (!busy || all_read) report_fail("anchor read outside a job scan");
                else if (anchor_addr_o != exp_addr)
                    report_fail($sformatf("anchor read %0d, expected %0d",
                                          anchor_addr_o, exp_addr));
                if (strobe_prev) report_fail("anchor reads on adjacent cycles");
                data_due = 1'b1;
                if (exp_addr == last_addr) begin
                    all_read = 1'b1;
                    done_cyc = cyc + occl_pkg::DRAIN_CYCLES;
                end
                exp_addr++;
            end
            strobe_prev = !anchor_cen_n_o;
            check_block();
            if (done_o) begin
                if (cyc != done_cyc) report_fail("done_o at the wrong cycle");
                if (kept_q.size() != 0 || writes != kept)
                    report_fail($sformatf("%0d block writes, expected %0d", writes, kept));
                busy     = 1'b0;
                done_cyc = -1;
            end else if (cyc == done_cyc) begin
                report_fail("done_o missing");
            end
        end
    end

endmodule

// ==== sim/tb_occl.sv ====
// random jobs on a near-identity view; anchor and block SRAMs are arrays with one cycle latency
`timescale 1ns/1ns

module tb_occl;

    logic                   clk = 1'b0;
    logic                   rstn, start_i;
    occl_pkg::anchor_addr_t anchor_first, anchor_last, anchor_addr;
    occl_pkg::cell_idx_t    cell_x, cell_y;
    occl_pkg::fix_t         tan_x, tan_y, z_span;
    occl_pkg::view_mat_t    view;
    occl_pkg::fp16_t [2:0]  anchor_data;
    logic                   anchor_cen_n, block_cen_n, block_we, done;
    occl_pkg::block_addr_t  block_addr;
    occl_pkg::block_word_t  block_wdata, block_rdata;
    logic [47:0]            anchor_mem [0:1023];
    occl_pkg::block_word_t  block_mem [0:63];
    int                     image_errors = 0;
    int                     seed;
    logic                   timed_out = 1'b0;

    always #2 clk = ~clk;

    occl_top UUT (
        .clk(clk), .rstn(rstn), .start_i(start_i),
        .anchor_first_i(anchor_first), .anchor_last_i(anchor_last),
        .cell_x_i(cell_x), .cell_y_i(cell_y), .tan_x_i(tan_x), .tan_y_i(tan_y),
        .z_span_i(z_span), .view_i(view),
        .anchor_cen_n_o(anchor_cen_n), .anchor_addr_o(anchor_addr), .anchor_data_i(anchor_data),
        .block_cen_n_o(block_cen_n), .block_we_o(block_we), .block_addr_o(block_addr),
        .block_wdata_o(block_wdata), .block_rdata_i(block_rdata), .done_o(done)
    );

    occl_checker chk (
        .clk(clk), .rstn(rstn), .start_i(start_i),
        .anchor_first_i(anchor_first), .anchor_last_i(anchor_last),
        .cell_x_i(cell_x), .cell_y_i(cell_y), .tan_x_i(tan_x), .tan_y_i(tan_y),
        .z_span_i(z_span), .view_i(view),
        .anchor_cen_n_o(anchor_cen_n), .anchor_addr_o(anchor_addr), .anchor_data_i(anchor_data),
        .block_cen_n_o(block_cen_n), .block_we_o(block_we), .block_addr_o(block_addr),
        .block_wdata_o(block_wdata), .done_o(done)
    );

    // sram models
    always @(posedge clk) begin
        if (!anchor_cen_n) anchor_data <= anchor_mem[anchor_addr];
        if (!block_cen_n) begin
            if (block_we) block_mem[block_addr] <= block_wdata;
            else block_rdata <= block_mem[block_addr];
        end
    end

    // exact fp16 from a count of eighths, |n| below 2048
    function automatic occl_pkg::fp16_t eighths_to_fp16(int n);
        int          mag;
        int          p;
        logic [10:0] m;
        mag = (n < 0) ? -n : n;
        if (mag > 2047) mag = 2047;
        if (mag == 0) return '0;
        p = $clog2(mag + 1) - 1;
        m = 11'(mag << (10 - p));
        return {n < 0, 5'(p + 12), m[9:0]};
    endfunction

    // grid column or row to a camera coordinate at depth z
    function automatic int grid_to_eighths(int g, real tan_r, real z);
        return $rtoi((real'(g) + 0.5 - 40.0) / 40.0 * tan_r * z * 8.0);
    endfunction

    task automatic make_anchor(int addr, int z_units);
        int  gx, gy, zn;
        real z;
        if ($urandom % 2) begin   // aimed at the cell
            gx = int'(cell_x) * 20 + int'($urandom % 20);
            gy = int'(cell_y) * 20 + int'($urandom % 20);
            zn = 8 + int'($urandom % (z_units * 8 - 8));
        end else begin
            gx = int'($urandom % 80);
            gy = int'($urandom % 80);
            zn = 8 + int'($urandom % (z_units * 12));
        end
        z = real'(zn) / 8.0;
        anchor_mem[addr] = {eighths_to_fp16(grid_to_eighths(gx, tan_x / 64.0, z)),
                            eighths_to_fp16(grid_to_eighths(gy, tan_y / 64.0, z)),
                            eighths_to_fp16(zn)};
    endtask

    task automatic run_job(int job);
        int z_units, len, n;
        @(negedge clk);
        len          = 1 + int'($urandom % 64);
        anchor_first = occl_pkg::anchor_addr_t'($urandom % (1024 - len));
        anchor_last  = anchor_first + occl_pkg::anchor_addr_t'(len - 1);
        cell_x       = occl_pkg::cell_idx_t'($urandom);
        cell_y       = occl_pkg::cell_idx_t'($urandom);
        tan_x        = occl_pkg::fix_t'(48 + $urandom % 33);
        tan_y        = occl_pkg::fix_t'(48 + $urandom % 33);
        z_units      = 20 + int'($urandom % 41);
        z_span       = occl_pkg::fix_t'(z_units << 6);
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (r == c) view[r][c] = eighths_to_fp16(7 + int'($urandom % 3));
                else if ($urandom % 4 == 0) view[r][c] = eighths_to_fp16(int'($urandom % 3) - 1);
                else view[r][c] = '0;
            end
        end
        for (int a = 0; a < len; a++) make_anchor(int'(anchor_first) + a, z_units);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        n = 0;
        while (!done && n < 1000) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("timeout: done_o never came in job %0d", job);
            timed_out = 1'b1;
        end else begin
            for (int i = 0; i < (1 << occl_pkg::BLOCK_ADDR_W); i++) begin
                if (block_mem[i] !== chk.model_mem[i]) begin
                    $display("Fail at %0t ns: block word %0d is %h, expected %h", $time, i,
                             block_mem[i], chk.model_mem[i]);
                    image_errors++;
                end
            end
        end
        repeat (3) @(negedge clk);
    endtask

    initial begin
        seed         = 33723;
        void'($urandom(seed));
        rstn         = 1'b0;
        start_i      = 1'b0;
        anchor_first = '0;
        anchor_last  = '0;
        cell_x       = '0;
        cell_y       = '0;
        tan_x        = '0;
        tan_y        = '0;
        z_span       = '0;
        view         = '0;
        anchor_data  = '0;
        block_rdata  = '0;
        for (int i = 0; i < 64; i++) block_mem[i] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (3) @(negedge clk);
        for (int j = 0; j < 12 && !timed_out; j++) run_job(j);
        $display("errors: checker %0d, image %0d; kept anchors %0d", chk.errors,
                 image_errors, chk.kept_total);
        if (chk.errors == 0 && image_errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
design/occl_pkg.sv
design/occl_ctrl.sv
design/anchor_transform.sv
design/frustum_project.sv
design/block_update.sv
design/occl_top.sv
sim/occl_checker.sv
sim/tb_occl.sv
